//--- pattern_comparator.f
hw/pattern_cmp_pkg.sv
hw/lane_error_tracker.sv
hw/aggregate_error_counter.sv
hw/pattern_comparator.sv
test/pattern_comparator_checker.sv
test/pattern_comparator_tb.sv

//--- Bender.yml
package:
  name: pattern_comparator

dependencies: {}

sources:
  # RTL, package first
  - files:
      - hw/pattern_cmp_pkg.sv
      - hw/lane_error_tracker.sv
      - hw/aggregate_error_counter.sv
      - hw/pattern_comparator.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/pattern_comparator_checker.sv
      - test/pattern_comparator_tb.sv

//--- test/pattern_comparator_tb.sv
`timescale 1ns/1ps

module pattern_comparator_tb;

    import pattern_cmp_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int MAX_ROWS   = 32;
    localparam int MARGIN     = 50;  // Spare cycles for the watchdog

    localparam lane_mask_t NO_LANE   = '0;
    localparam lane_mask_t ALL_LANES = '1;
    localparam lane_mask_t LANE0     = 16'h0001;
    localparam lane_mask_t LANE1     = 16'h0002;
    localparam lane_mask_t LANE5     = 16'h0020;
    localparam lane_mask_t LANE8     = 16'h0100;

    // One table row that is applied reps times and checked after the last beat
    typedef struct packed {
        cmp_mode_e   mode;
        cmp_phase_e  phase;
        logic        valid;
        lane_mask_t  sel_a;      // Lanes flipped with mask_a
        lane_word_t  mask_a;
        lane_mask_t  sel_b;      // Lanes flipped with mask_b
        lane_word_t  mask_b;
        logic [15:0] reps;
        lane_cnt_t   lane_max;
        agg_cnt_t    agg_max;
        lane_mask_t  exp_good;
        agg_cnt_t    exp_count;
        logic        exp_ok;
    } stim_row_t;

    logic          i_clk;
    logic          i_rst_n;
    cmp_mode_e     i_mode;
    cmp_phase_e    i_phase;
    logic          i_beat_valid;
    pattern_beat_t i_beat;
    err_thresh_t   i_thresh;
    lane_mask_t    o_lane_good;
    agg_cnt_t      o_error_count;
    logic          o_aggregate_ok;

    stim_row_t   stim_rows [MAX_ROWS];
    int          num_rows    = 0;
    logic        rows_ready  = 1'b0;
    logic [31:0] lfsr_state  = 32'h457;

    pattern_comparator pattern_comparator_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mode         (i_mode),
        .i_phase        (i_phase),
        .i_beat_valid   (i_beat_valid),
        .i_beat         (i_beat),
        .i_thresh       (i_thresh),
        .o_lane_good    (o_lane_good),
        .o_error_count  (o_error_count),
        .o_aggregate_ok (o_aggregate_ok)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // One LFSR step per generated bit
    task automatic fill_local_words(output lane_bus_t words);
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int b = 0; b < LANE_W; b++) begin
                lfsr_state  = lfsr_next(lfsr_state);
                words[l][b] = lfsr_state[0];
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_lane_mask(input string name, input lane_mask_t exp_val,
                                   input lane_mask_t act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("ERR %0t %s expected %h actual %h",
                                $time, name, exp_val, act_val));
        end
    endtask

    task automatic check_count(input string name, input agg_cnt_t exp_val,
                               input agg_cnt_t act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("ERR %0t %s expected %0d actual %0d",
                                $time, name, exp_val, act_val));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("ERR %0t %s expected %b actual %b",
                                $time, name, exp_val, act_val));
        end
    endtask

    // Bound assertions count their own failures
    task automatic check_assertions(input string where);
        if (pattern_comparator_inst.pattern_comparator_checker_inst.violation_count != 0) begin
            abort_run($sformatf("A checker assertion failed %s", where));
        end
    endtask

    task automatic add_row(input cmp_mode_e mode, input cmp_phase_e phase, input logic valid,
                           input lane_mask_t sel_a, input lane_word_t mask_a,
                           input lane_mask_t sel_b, input lane_word_t mask_b,
                           input int reps, input lane_cnt_t lane_max, input agg_cnt_t agg_max,
                           input lane_mask_t exp_good, input agg_cnt_t exp_count,
                           input logic exp_ok);
        stim_row_t row;
        if (num_rows >= MAX_ROWS) begin
            abort_run("Stimulus table is larger than its storage");
        end
        row.mode      = mode;
        row.phase     = phase;
        row.valid     = valid;
        row.sel_a     = sel_a;
        row.mask_a    = mask_a;
        row.sel_b     = sel_b;
        row.mask_b    = mask_b;
        row.reps      = reps[15:0];
        row.lane_max  = lane_max;
        row.agg_max   = agg_max;
        row.exp_good  = exp_good;
        row.exp_count = exp_count;
        row.exp_ok    = exp_ok;
        stim_rows[num_rows] = row;
        num_rows++;
    endtask

    task automatic load_table();
        add_row(MODE_AGGREGATE, PH_CLEAR, 1'b0, NO_LANE, 32'h0, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, ALL_LANES, 16'd0, 1'b1);
        // Lane 5 takes 3 errors per beat against a limit of 7
        add_row(MODE_PER_LANE, PH_PATTERN, 1'b1, LANE5, 32'h0000_0007, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, ALL_LANES, 16'd0, 1'b1);
        add_row(MODE_PER_LANE, PH_PATTERN, 1'b1, LANE5, 32'h0000_0007, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, ALL_LANES, 16'd0, 1'b1);
        add_row(MODE_PER_LANE, PH_PATTERN, 1'b1, LANE5, 32'h0000_0007, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, 16'hFFDF, 16'd0, 1'b1);
        add_row(MODE_PER_LANE, PH_PATTERN, 1'b1, NO_LANE, 32'h0, NO_LANE, 32'h0,
                3, 12'd7, 16'd20, 16'hFFDF, 16'd0, 1'b1);  // Sticky drop
        // Invalid beats with every bit wrong
        add_row(MODE_PER_LANE, PH_PER_LANE_IDE, 1'b0, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                2, 12'd7, 16'd20, 16'hFFDF, 16'd0, 1'b1);
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b0, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                2, 12'd7, 16'd20, 16'hFFDF, 16'd0, 1'b1);
        // Same 4 positions on all lanes count once
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b1, ALL_LANES, 32'h0000_F000, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, 16'hFFDF, 16'd4, 1'b1);
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b1, ALL_LANES, 32'h0000_F000, NO_LANE, 32'h0,
                2, 12'd7, 16'd20, 16'hFFDF, 16'd12, 1'b1);
        add_row(MODE_AGGREGATE, PH_PER_LANE_IDE, 1'b1, LANE0, 32'h0000_000F, LANE8, 32'h00F0_0000,
                1, 12'd7, 16'd20, 16'hFFDF, 16'd20, 1'b1);  // Disjoint positions add 4 + 4
        // One bit past the aggregate limit
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b1, LANE1, 32'h8000_0000, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, 16'hFFDF, 16'd21, 1'b0);
        add_row(MODE_AGGREGATE, PH_IDLE, 1'b0, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, 16'hFFDF, 16'd21, 1'b0);
        add_row(MODE_AGGREGATE, PH_CLEAR, 1'b1, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, ALL_LANES, 16'd0, 1'b1);
        // Every lane over its limit in one beat
        add_row(MODE_PER_LANE, PH_PATTERN, 1'b1, ALL_LANES, 32'h0000_00FF, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, 16'h0000, 16'd0, 1'b1);
        add_row(MODE_PER_LANE, PH_CLEAR, 1'b0, NO_LANE, 32'h0, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, ALL_LANES, 16'd0, 1'b1);
        // 32 per beat up to saturation
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b1, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                2047, 12'd7, 16'hFFFE, ALL_LANES, 16'd65504, 1'b1);
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b1, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                1, 12'd7, 16'hFFFE, ALL_LANES, 16'hFFFF, 1'b0);
        add_row(MODE_AGGREGATE, PH_PATTERN, 1'b1, ALL_LANES, 32'hFFFF_FFFF, NO_LANE, 32'h0,
                3, 12'd7, 16'hFFFE, ALL_LANES, 16'hFFFF, 1'b0);
        add_row(MODE_AGGREGATE, PH_CLEAR, 1'b0, NO_LANE, 32'h0, NO_LANE, 32'h0,
                1, 12'd7, 16'd20, ALL_LANES, 16'd0, 1'b1);
    endtask

    // Drives on falling edges and checks on the falling edge after the last beat
    task automatic apply_row(input int idx);
        stim_row_t     row;
        lane_bus_t     local_words;
        lane_bus_t     rx_words;
        pattern_beat_t beat;
        row = stim_rows[idx];
        for (int r = 0; r < int'(row.reps); r++) begin
            fill_local_words(local_words);
            for (int l = 0; l < NUM_LANES; l++) begin
                rx_words[l] = local_words[l]
                            ^ ({LANE_W{row.sel_a[l]}} & row.mask_a)
                            ^ ({LANE_W{row.sel_b[l]}} & row.mask_b);
            end
            beat.local_gen         = local_words;
            beat.rx_data           = rx_words;
            i_mode                 = row.mode;
            i_phase                = row.phase;
            i_beat_valid           = row.valid;
            i_beat                 = beat;
            i_thresh.lane_max      = row.lane_max;
            i_thresh.aggregate_max = row.agg_max;
            @(negedge i_clk);
        end
        check_lane_mask("o_lane_good", row.exp_good, o_lane_good);
        check_count("o_error_count", row.exp_count, o_error_count);
        check_flag("o_aggregate_ok", row.exp_ok, o_aggregate_ok);
        check_assertions($sformatf("by row %0d", idx));
    endtask

    initial begin : watchdog
        int total_beats;
        int limit_ns;
        wait (rows_ready);
        total_beats = 0;
        for (int i = 0; i < num_rows; i++) begin
            total_beats += int'(stim_rows[i].reps);
        end
        limit_ns = (RST_CYCLES + total_beats + num_rows + MARGIN) * CLK_PERIOD;
        #(limit_ns);
        abort_run($sformatf("Timeout: the run did not finish within %0d ns", limit_ns));
    end

    initial begin : stimulus
        i_rst_n      = 1'b0;
        i_mode       = MODE_AGGREGATE;
        i_phase      = PH_IDLE;
        i_beat_valid = 1'b0;
        i_beat       = '0;
        i_thresh     = '0;
        load_table();
        rows_ready = 1'b1;
        repeat (RST_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        // Values left by reset
        check_lane_mask("o_lane_good", ALL_LANES, o_lane_good);
        check_count("o_error_count", 16'd0, o_error_count);
        check_flag("o_aggregate_ok", 1'b1, o_aggregate_ok);
        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
        end
        // The assertions judge the last edge one cycle later
        @(negedge i_clk);
        check_assertions("after the last row");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- test/pattern_comparator_checker.sv
`timescale 1ns/1ps

module pattern_comparator_checker (
    input logic                        i_clk,
    input logic                        i_rst_n,
    input pattern_cmp_pkg::cmp_phase_e  i_phase,
    input pattern_cmp_pkg::err_thresh_t i_thresh,
    input pattern_cmp_pkg::lane_mask_t  i_lane_good,
    input pattern_cmp_pkg::agg_cnt_t    i_error_count,
    input logic                        i_aggregate_ok
);

    import pattern_cmp_pkg::*;

    int unsigned violation_count = 0;  // Read by the testbench

    // A dropped lane only comes back through the clear phase
    lane_good_never_rises: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_phase != PH_CLEAR) |=> ((i_lane_good & ~$past(i_lane_good)) == '0)
    ) else begin
        violation_count++;
        $error("lane-good bit rose outside the clear phase");
    end

    // Count only moves up between clear phases
    count_never_decreases: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_phase != PH_CLEAR) |=> (i_error_count >= $past(i_error_count))
    ) else begin
        violation_count++;
        $error("error count went down outside the clear phase");
    end

    aggregate_ok_matches: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_aggregate_ok == (i_error_count <= i_thresh.aggregate_max)
    ) else begin
        violation_count++;
        $error("aggregate ok flag disagrees with count and threshold");
    end

endmodule

bind pattern_comparator pattern_comparator_checker pattern_comparator_checker_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_phase        (i_phase),
    .i_thresh       (i_thresh),
    .i_lane_good    (o_lane_good),
    .i_error_count  (o_error_count),
    .i_aggregate_ok (o_aggregate_ok)
);

//--- hw/pattern_comparator.sv
`timescale 1ns/1ps

module pattern_comparator (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  pattern_cmp_pkg::cmp_mode_e     i_mode,
    input  pattern_cmp_pkg::cmp_phase_e    i_phase,
    input  logic                         i_beat_valid,   // No back-pressure
    input  pattern_cmp_pkg::pattern_beat_t i_beat,
    input  pattern_cmp_pkg::err_thresh_t   i_thresh,
    output pattern_cmp_pkg::lane_mask_t    o_lane_good,
    output pattern_cmp_pkg::agg_cnt_t      o_error_count,
    output logic                         o_aggregate_ok
);

    // Per-lane mode result
    lane_error_tracker lane_error_tracker_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_mode       (i_mode),
        .i_phase      (i_phase),
        .i_beat_valid (i_beat_valid),
        .i_beat       (i_beat),
        .i_lane_max   (i_thresh.lane_max),
        .o_lane_good  (o_lane_good)
    );

    // Aggregate mode result
    aggregate_error_counter aggregate_error_counter_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_mode          (i_mode),
        .i_phase         (i_phase),
        .i_beat_valid    (i_beat_valid),
        .i_beat          (i_beat),
        .i_aggregate_max (i_thresh.aggregate_max),
        .o_error_count   (o_error_count),
        .o_aggregate_ok  (o_aggregate_ok)
    );

endmodule

//--- hw/aggregate_error_counter.sv
`timescale 1ns/1ps

module aggregate_error_counter (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  pattern_cmp_pkg::cmp_mode_e     i_mode,
    input  pattern_cmp_pkg::cmp_phase_e    i_phase,
    input  logic                         i_beat_valid,
    input  pattern_cmp_pkg::pattern_beat_t i_beat,
    input  pattern_cmp_pkg::agg_cnt_t      i_aggregate_max,
    output pattern_cmp_pkg::agg_cnt_t      o_error_count,
    output logic                         o_aggregate_ok
);

    import pattern_cmp_pkg::*;

    lane_word_t         mismatch_or;  // Bit position failed on any lane
    logic [POP_W-1:0]   err_bits;
    logic [AGG_CNT_W:0] sum;          // Spare top bit flags overflow
    agg_cnt_t           count_next;
    logic               clear;
    logic               count_en;

    assign clear    = (i_phase == PH_CLEAR);
    assign count_en = i_beat_valid && (i_mode == MODE_AGGREGATE);

    // Fold the per-lane mismatches onto one word
    always_comb begin
        mismatch_or = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            mismatch_or = mismatch_or | (i_beat.rx_data[l] ^ i_beat.local_gen[l]);
        end
    end

    // A position that fails on several lanes counts once
    assign err_bits = popcount_word(mismatch_or);

    assign sum        = {1'b0, o_error_count} + (AGG_CNT_W + 1)'(err_bits);
    assign count_next = sum[AGG_CNT_W] ? '1 : sum[AGG_CNT_W-1:0];  // Saturate at max

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_error_count <= '0;
        end else if (clear) begin
            o_error_count <= '0;
        end else if (count_en) begin
            o_error_count <= count_next;
        end
    end

    // Good while the total has not passed the limit
    assign o_aggregate_ok = (o_error_count <= i_aggregate_max);

endmodule

//--- hw/lane_error_tracker.sv
`timescale 1ns/1ps

module lane_error_tracker (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  pattern_cmp_pkg::cmp_mode_e     i_mode,
    input  pattern_cmp_pkg::cmp_phase_e    i_phase,
    input  logic                         i_beat_valid,
    input  pattern_cmp_pkg::pattern_beat_t i_beat,
    input  pattern_cmp_pkg::lane_cnt_t     i_lane_max,
    output pattern_cmp_pkg::lane_mask_t    o_lane_good  // 1 = lane within its limit
);

    import pattern_cmp_pkg::*;

    logic clear;     // Clear phase restarts every lane
    logic count_en;  // Beat accepted and counted per lane

    assign clear    = (i_phase == PH_CLEAR);
    assign count_en = i_beat_valid && (i_mode == MODE_PER_LANE);

    // One counter and one sticky flag per lane
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_word_t          mismatch;
        logic [POP_W-1:0]    err_bits;
        logic [LANE_CNT_W:0] sum;       // One spare bit to catch overflow
        lane_cnt_t           cnt_q;
        lane_cnt_t           cnt_next;
        logic                over_limit;
        logic                good_q;

        assign mismatch = i_beat.rx_data[l] ^ i_beat.local_gen[l];
        assign err_bits = popcount_word(mismatch);

        // Saturating accumulate, stays at all ones once reached
        assign sum      = {1'b0, cnt_q} + (LANE_CNT_W + 1)'(err_bits);
        assign cnt_next = sum[LANE_CNT_W] ? '1 : sum[LANE_CNT_W-1:0];

        // Judged on the count including this beat
        assign over_limit = (cnt_next > i_lane_max);

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                cnt_q <= '0;
            end else if (clear) begin
                cnt_q <= '0;
            end else if (count_en) begin
                cnt_q <= cnt_next;
            end
        end

        // Sticky, only the clear phase or reset brings it back
        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                good_q <= 1'b1;
            end else if (clear) begin
                good_q <= 1'b1;
            end else if (count_en && over_limit) begin
                good_q <= 1'b0;
            end
        end

        assign o_lane_good[l] = good_q;
    end

endmodule

//--- hw/pattern_cmp_pkg.sv
package pattern_cmp_pkg;

    // Link geometry
    localparam int NUM_LANES  = 16;
    localparam int LANE_W     = 32;

    // Counter widths
    localparam int LANE_CNT_W = 12;  // Per-lane error count
    localparam int AGG_CNT_W  = 16;  // Aggregate error count
    localparam int POP_W      = 6;   // Holds 0 to 32 set bits of one lane word

    typedef logic [LANE_W-1:0]                   lane_word_t;
    typedef logic [NUM_LANES-1:0][LANE_W-1:0]    lane_bus_t;   // Lane 0 in the low word
    typedef logic [NUM_LANES-1:0]                lane_mask_t;  // One bit per lane
    typedef logic [LANE_CNT_W-1:0]               lane_cnt_t;
    typedef logic [AGG_CNT_W-1:0]                agg_cnt_t;

    // Training phase as driven by the link trainer
    typedef enum logic [1:0] {
        PH_IDLE         = 2'b00,
        PH_CLEAR        = 2'b01,  // Counters and flags restart
        PH_PATTERN      = 2'b10,
        PH_PER_LANE_IDE = 2'b11
    } cmp_phase_e;

    typedef enum logic {
        MODE_AGGREGATE = 1'b0,  // All lanes folded into one count
        MODE_PER_LANE  = 1'b1   // One count per lane
    } cmp_mode_e;

    // One accepted beat, expected and received side by side
    typedef struct packed {
        lane_bus_t local_gen;  // Locally generated pattern
        lane_bus_t rx_data;    // Pattern seen on the lanes
    } pattern_beat_t;

    // Error limits, exceeded means failed
    typedef struct packed {
        lane_cnt_t lane_max;
        agg_cnt_t  aggregate_max;
    } err_thresh_t;

    // Number of set bits in one lane word
    function automatic logic [POP_W-1:0] popcount_word(input lane_word_t word);
        logic [POP_W-1:0] cnt;
        cnt = '0;
        for (int b = 0; b < LANE_W; b++) begin
            cnt = cnt + POP_W'(word[b]);
        end
        return cnt;
    endfunction

endpackage
